/* source/ecc_pkg.sv */
package ecc_pkg;

    // codeword geometry.
    localparam int DATA_W = 28;
    localparam int PAR_W  = 7;

    typedef logic [DATA_W-1:0] ecc_data_t;
    typedef logic [PAR_W-1:0]  ecc_parity_t;

    // ------------------------------
    // check bit generation
    // ------------------------------

    // each check bit is the xor of a fixed set of data bits.
    // bit 5 only guards the two top data bits.
    function automatic ecc_parity_t ecc_parity(input ecc_data_t d);
        ecc_parity_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^
               d[13] ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^
               d[13] ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^
               d[15] ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[18] ^
               d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18] ^
               d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[5] = d[26] ^ d[27];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^
               d[12] ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^
               d[26] ^ d[27];
        return p;
    endfunction

endpackage

/* source/mem_cmd_pkg.sv */
package mem_cmd_pkg;

    // scratch array size.
    localparam int MEM_DEPTH = 24;
    localparam int ADDR_W    = 5;

    // error counters saturate at all ones.
    localparam int CNT_W = 8;

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [CNT_W-1:0]  err_cnt_t;

    // codes 6 and 7 are illegal.
    typedef enum logic [2:0] {
        OP_NOP      = 3'd0,
        OP_WRITE    = 3'd1,
        OP_READ     = 3'd2,
        OP_READ_RAW = 3'd3,
        OP_FLIP     = 3'd4,
        OP_CLR_CNT  = 3'd5
    } mem_op_e;

    typedef enum logic [1:0] {
        ST_OK            = 2'd0,
        ST_CORRECTED     = 2'd1,
        ST_UNCORRECTABLE = 2'd2,
        ST_BAD_CMD       = 2'd3
    } rsp_status_e;

endpackage

/* source/ecc_cmd_if.sv */
interface ecc_cmd_if
    import ecc_pkg::*, mem_cmd_pkg::*;
();

    // one strobe per command, fields hold only while it is high.
    logic        valid;
    mem_op_e     op;
    mem_addr_t   addr;
    ecc_data_t   data;

    // check bit flip pattern, used by OP_FLIP only.
    ecc_parity_t pflip;

    // command was rejected in decode.
    logic        bad;

    modport src (
        output valid,
        output op,
        output addr,
        output data,
        output pflip,
        output bad
    );

    modport dst (
        input valid,
        input op,
        input addr,
        input data,
        input pflip,
        input bad
    );

endinterface

/* source/ecc_word_if.sv */
interface ecc_word_if
    import ecc_pkg::*, mem_cmd_pkg::*;
();

    // one strobe per command, fields hold only while it is high.
    logic        valid;
    mem_op_e     op;
    logic        bad;

    // codeword as fetched from the array.
    ecc_data_t   data;
    ecc_parity_t parity;

    modport src (
        output valid,
        output op,
        output bad,
        output data,
        output parity
    );

    modport dst (
        input valid,
        input op,
        input bad,
        input data,
        input parity
    );

endinterface

/* source/ecc_secded_28.sv */
module ecc_secded_28
    import ecc_pkg::*;
(
    input  ecc_data_t   data_in,
    input  ecc_parity_t parity_in,
    input  logic        bypass,
    output ecc_data_t   data_out,
    output ecc_parity_t parity_out,
    output ecc_data_t   mask,
    output logic        sbit_err,
    output logic        dbit_err
);

    ecc_parity_t syndrome;
    logic        err_single;
    logic        err_double;

    assign parity_out = ecc_parity(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // ------------------------------
    // syndrome decode
    // ------------------------------

    // each data bit has its own odd syndrome.
    always_comb begin
        mask       = '0;
        err_single = 1'b1;
        err_double = 1'b0;
        case (syndrome)
            7'b0000000: err_single = 1'b0;
            7'b1000011: mask[0]  = 1'b1;
            7'b1000101: mask[1]  = 1'b1;
            7'b1000110: mask[2]  = 1'b1;
            7'b0000111: mask[3]  = 1'b1;
            7'b1001001: mask[4]  = 1'b1;
            7'b1001010: mask[5]  = 1'b1;
            7'b0001011: mask[6]  = 1'b1;
            7'b1001100: mask[7]  = 1'b1;
            7'b0001101: mask[8]  = 1'b1;
            7'b0001110: mask[9]  = 1'b1;
            7'b1001111: mask[10] = 1'b1;
            7'b1010001: mask[11] = 1'b1;
            7'b1010010: mask[12] = 1'b1;
            7'b0010011: mask[13] = 1'b1;
            7'b1010100: mask[14] = 1'b1;
            7'b0010101: mask[15] = 1'b1;
            7'b0010110: mask[16] = 1'b1;
            7'b1010111: mask[17] = 1'b1;
            7'b1011000: mask[18] = 1'b1;
            7'b0011001: mask[19] = 1'b1;
            7'b0011010: mask[20] = 1'b1;
            7'b1011011: mask[21] = 1'b1;
            7'b0011100: mask[22] = 1'b1;
            7'b1011101: mask[23] = 1'b1;
            7'b1011110: mask[24] = 1'b1;
            7'b0011111: mask[25] = 1'b1;
            7'b1100001: mask[26] = 1'b1;
            7'b1100010: mask[27] = 1'b1;
            // a flipped check bit leaves the data alone.
            7'b1000000, 7'b0100000, 7'b0010000, 7'b0001000,
            7'b0000100, 7'b0000010, 7'b0000001: begin
                mask = '0;
            end
            default: begin
                err_single = 1'b0;
                err_double = 1'b1;
            end
        endcase
    end

    // ------------------------------
    // correction and flags
    // ------------------------------

    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = !bypass && err_single;
    assign dbit_err = !bypass && err_double;

endmodule

/* source/cmd_decode.sv */
module cmd_decode
    import ecc_pkg::*, mem_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  logic [2:0]  cmd_op,
    input  mem_addr_t   cmd_addr,
    input  ecc_data_t   cmd_data,
    input  ecc_parity_t cmd_pflip,
    ecc_cmd_if.src      cmd
);

    mem_op_e op_in;
    logic    op_bad;
    logic    uses_addr;
    logic    addr_bad;
    logic    cmd_bad;

    // opcode check.
    always_comb begin
        op_in     = mem_op_e'(cmd_op);
        op_bad    = 1'b0;
        uses_addr = 1'b0;
        case (cmd_op)
            OP_NOP, OP_CLR_CNT: uses_addr = 1'b0;
            OP_WRITE, OP_READ, OP_READ_RAW, OP_FLIP: uses_addr = 1'b1;
            default: op_bad = 1'b1;
        endcase
    end

    // address only matters for array commands.
    assign addr_bad = uses_addr && (cmd_addr >= ADDR_W'(MEM_DEPTH));
    assign cmd_bad  = op_bad || addr_bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= cmd_valid;
        end
    end

    // rejected commands turn into a nop so nothing downstream acts on them.
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            cmd.op    <= cmd_bad ? OP_NOP : op_in;
            cmd.addr  <= cmd_addr;
            cmd.data  <= cmd_data;
            cmd.pflip <= cmd_pflip;
            cmd.bad   <= cmd_bad;
        end
    end

endmodule

/* source/mem_execute.sv */
module mem_execute
    import ecc_pkg::*, mem_cmd_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    ecc_cmd_if.dst  cmd,
    ecc_word_if.src word
);

    // ------------------------------
    // codeword array
    // ------------------------------

    ecc_data_t   mem_data [MEM_DEPTH];
    ecc_parity_t mem_par  [MEM_DEPTH];
    ecc_parity_t wr_par;

    assign wr_par = ecc_parity(cmd.data);

    // writes store fresh check bits, flips corrupt the stored word in place.
    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            case (cmd.op)
                OP_WRITE: begin
                    mem_data[cmd.addr] <= cmd.data;
                    mem_par[cmd.addr]  <= wr_par;
                end
                OP_FLIP: begin
                    mem_data[cmd.addr] <= mem_data[cmd.addr] ^ cmd.data;
                    mem_par[cmd.addr]  <= mem_par[cmd.addr] ^ cmd.pflip;
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------
    // fetch
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            word.valid <= 1'b0;
        end else begin
            word.valid <= cmd.valid;
        end
    end

    // old contents go out, except a write which returns what it stored.
    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            word.op  <= cmd.op;
            word.bad <= cmd.bad;
            if (cmd.op == OP_WRITE) begin
                word.data   <= cmd.data;
                word.parity <= wr_par;
            end else begin
                word.data   <= mem_data[cmd.addr];
                word.parity <= mem_par[cmd.addr];
            end
        end
    end

endmodule

/* source/result_check.sv */
module result_check
    import ecc_pkg::*, mem_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    ecc_word_if.dst     word,
    output logic        rsp_valid,
    output rsp_status_e rsp_status,
    output ecc_data_t   rsp_data,
    output ecc_parity_t rsp_parity,
    output err_cnt_t    sbit_cnt,
    output err_cnt_t    dbit_cnt
);

    ecc_data_t   fix_data;
    logic        sbit_err;
    logic        dbit_err;
    logic        is_read;
    rsp_status_e status_nxt;

    assign is_read = (word.op == OP_READ);

    ecc_secded_28 u_secded (
        .data_in    (word.data),
        .parity_in  (word.parity),
        .bypass     (word.op == OP_READ_RAW),
        .data_out   (fix_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // only a corrected read reports the codec's verdict.
    always_comb begin
        status_nxt = ST_OK;
        if (word.bad) begin
            status_nxt = ST_BAD_CMD;
        end else if (is_read && dbit_err) begin
            status_nxt = ST_UNCORRECTABLE;
        end else if (is_read && sbit_err) begin
            status_nxt = ST_CORRECTED;
        end
    end

    always_ff @(posedge clk) begin
        if (word.valid) begin
            rsp_status <= status_nxt;
            rsp_data   <= is_read ? fix_data : word.data;
            rsp_parity <= word.parity;
        end
    end

    // ------------------------------
    // response strobe and counters
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            sbit_cnt  <= '0;
            dbit_cnt  <= '0;
        end else begin
            rsp_valid <= word.valid;
            if (word.valid && word.op == OP_CLR_CNT) begin
                sbit_cnt <= '0;
                dbit_cnt <= '0;
            end else if (word.valid && is_read) begin
                if (sbit_err && sbit_cnt != '1) begin
                    sbit_cnt <= sbit_cnt + 1'b1;
                end
                if (dbit_err && dbit_cnt != '1) begin
                    dbit_cnt <= dbit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* source/ecc_mem_top.sv */
module ecc_mem_top
    import ecc_pkg::*, mem_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  logic [2:0]  cmd_op,
    input  mem_addr_t   cmd_addr,
    input  ecc_data_t   cmd_data,
    input  ecc_parity_t cmd_pflip,
    output logic        rsp_valid,
    output rsp_status_e rsp_status,
    output ecc_data_t   rsp_data,
    output ecc_parity_t rsp_parity,
    output err_cnt_t    sbit_cnt,
    output err_cnt_t    dbit_cnt
);

    // decode -> execute -> result, one register per stage.
    ecc_cmd_if  cmd_bus ();
    ecc_word_if word_bus ();

    cmd_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .cmd_pflip (cmd_pflip),
        .cmd       (cmd_bus.src)
    );

    mem_execute u_execute (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd_bus.dst),
        .word (word_bus.src)
    );

    result_check u_result (
        .clk        (clk),
        .rst        (rst),
        .word       (word_bus.dst),
        .rsp_valid  (rsp_valid),
        .rsp_status (rsp_status),
        .rsp_data   (rsp_data),
        .rsp_parity (rsp_parity),
        .sbit_cnt   (sbit_cnt),
        .dbit_cnt   (dbit_cnt)
    );

endmodule

/* dv/ecc_mem_tb.sv */
module ecc_mem_tb
    import ecc_pkg::*, mem_cmd_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    logic [2:0]  cmd_op;
    mem_addr_t   cmd_addr;
    ecc_data_t   cmd_data;
    ecc_parity_t cmd_pflip;
    logic        rsp_valid;
    rsp_status_e rsp_status;
    ecc_data_t   rsp_data;
    ecc_parity_t rsp_parity;
    err_cnt_t    sbit_cnt;
    err_cnt_t    dbit_cnt;

    // one queued expectation.
    typedef struct packed {
        rsp_status_e st;
        // low where the stored word is unknown.
        logic        chk;
        ecc_data_t   d;
        ecc_parity_t p;
        err_cnt_t    sc;
        err_cnt_t    dc;
        int          cyc;
    } expect_t;

    // data bits covered by each check bit.
    localparam ecc_data_t PAR_MASK [PAR_W] = '{
        28'h6AAAD5B, 28'hB33366D, 28'h3C3C78E, 28'h3FC07F0,
        28'h3FFF800, 28'hC000000, 28'hDA65CB7
    };

    integer      seed;
    int          errors;
    int          checked;
    int          cyc = 0;
    expect_t     pend [$];
    expect_t     got;
    ecc_data_t   sh_d [MEM_DEPTH];
    ecc_parity_t sh_p [MEM_DEPTH];
    err_cnt_t    sh_sc;
    err_cnt_t    sh_dc;

    ecc_mem_top DUT (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_pflip  (cmd_pflip),
        .rsp_valid  (rsp_valid),
        .rsp_status (rsp_status),
        .rsp_data   (rsp_data),
        .rsp_parity (rsp_parity),
        .sbit_cnt   (sbit_cnt),
        .dbit_cnt   (dbit_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic ecc_parity_t ref_parity(input ecc_data_t d);
        ecc_parity_t p;
        for (int i = 0; i < PAR_W; i++) begin
            p[i] = ^(d & PAR_MASK[i]);
        end
        return p;
    endfunction

    // a single data bit error leaves that bit's own column as syndrome.
    function automatic int syndrome_bit(input ecc_parity_t syn);
        int hit;
        hit = -1;
        for (int j = 0; j < DATA_W; j++) begin
            if (ref_parity(ecc_data_t'(1) << j) == syn) hit = j;
        end
        return hit;
    endfunction

    function automatic ecc_data_t rand_data();
        logic [31:0] r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------

    task automatic check_status(input string name, input rsp_status_e exp,
                                input rsp_status_e act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input ecc_data_t exp, input ecc_data_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_parity(input string name, input ecc_parity_t exp,
                                input ecc_parity_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input err_cnt_t exp, input err_cnt_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // ------------------------------
    // command driver
    // ------------------------------

    // drives one command for one cycle and queues what it must return.
    task automatic issue_cmd(input logic [2:0] op, input mem_addr_t addr,
                             input ecc_data_t d, input ecc_parity_t pf);
        expect_t     e;
        ecc_parity_t syn;
        int          hit;
        logic        bad;
        bad = (op > 3'd5) || (op != OP_NOP && op != OP_CLR_CNT && int'(addr) >= MEM_DEPTH);
        e = '0;
        e.cyc = cyc;
        e.st = ST_OK;
        if (bad) begin
            e.st = ST_BAD_CMD;
        end else if (op == OP_WRITE) begin
            sh_d[addr] = d;
            sh_p[addr] = ref_parity(d);
            e.chk = 1'b1;
            e.d = d;
            e.p = sh_p[addr];
        end else if (op == OP_READ || op == OP_READ_RAW || op == OP_FLIP) begin
            e.chk = 1'b1;
            e.d = sh_d[addr];
            e.p = sh_p[addr];
            if (op == OP_FLIP) begin
                sh_d[addr] = sh_d[addr] ^ d;
                sh_p[addr] = sh_p[addr] ^ pf;
            end
            syn = e.p ^ ref_parity(e.d);
            if (op == OP_READ && syn != '0) begin
                if ($countones(syn) % 2 == 1) begin
                    e.st = ST_CORRECTED;
                    hit = syndrome_bit(syn);
                    if (hit >= 0) e.d = e.d ^ (ecc_data_t'(1) << hit);
                    if (sh_sc != 8'hff) sh_sc = sh_sc + 8'd1;
                end else begin
                    e.st = ST_UNCORRECTABLE;
                    if (sh_dc != 8'hff) sh_dc = sh_dc + 8'd1;
                end
            end
        end else if (op == OP_CLR_CNT) begin
            sh_sc = '0;
            sh_dc = '0;
        end
        e.sc = sh_sc;
        e.dc = sh_dc;
        pend.push_back(e);
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_addr = addr;
        cmd_data = d;
        cmd_pflip = pf;
        @(negedge clk);
    endtask

    task automatic wait_responses();
        int n;
        cmd_valid = 1'b0;
        n = 0;
        while (pend.size() != 0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (pend.size() != 0) begin
            errors++;
            $display("timed out with %0d responses still missing", pend.size());
            pend.delete();
        end
    endtask

    // each response is matched against the oldest queued expectation.
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && rsp_valid) begin
                if (pend.size() == 0) begin
                    errors++;
                    $display("a response came back with no command outstanding");
                end else begin
                    got = pend.pop_front();
                    checked++;
                    if (cyc - got.cyc != 3) begin
                        errors++;
                        $display("response took %0d cycles instead of 3", cyc - got.cyc);
                    end
                    check_status("rsp_status", got.st, rsp_status);
                    if (got.chk) begin
                        check_data("rsp_data", got.d, rsp_data);
                        check_parity("rsp_parity", got.p, rsp_parity);
                    end
                    check_count("sbit_cnt", got.sc, sbit_cnt);
                    check_count("dbit_cnt", got.dc, dbit_cnt);
                end
            end
        end
    end

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic clean_write_read();
        for (int a = 0; a < MEM_DEPTH; a++) issue_cmd(OP_WRITE, mem_addr_t'(a), rand_data(), '0);
        for (int a = 0; a < MEM_DEPTH; a++) issue_cmd(OP_READ, mem_addr_t'(a), '0, '0);
        wait_responses();
    endtask

    task automatic single_data_flips();
        mem_addr_t a;
        a = '0;
        for (int b = 0; b < DATA_W; b++) begin
            a = mem_addr_t'(b % MEM_DEPTH);
            issue_cmd(OP_WRITE, a, rand_data(), '0);
            issue_cmd(OP_FLIP, a, ecc_data_t'(1) << b, '0);
            issue_cmd(OP_READ, a, '0, '0);
            issue_cmd(OP_READ_RAW, a, '0, '0);
        end
        // keep reading until the counter sticks at all ones.
        for (int k = 0; k < 240; k++) issue_cmd(OP_READ, a, '0, '0);
        wait_responses();
        check_count("sbit_cnt", 8'hff, sbit_cnt);
    endtask

    task automatic parity_flips();
        issue_cmd(OP_CLR_CNT, '0, '0, '0);
        for (int p = 0; p < PAR_W; p++) begin
            issue_cmd(OP_WRITE, mem_addr_t'(p + 8), rand_data(), '0);
            issue_cmd(OP_FLIP, mem_addr_t'(p + 8), '0, ecc_parity_t'(1) << p);
            issue_cmd(OP_READ, mem_addr_t'(p + 8), '0, '0);
        end
        wait_responses();
        check_count("sbit_cnt", 8'd7, sbit_cnt);
    endtask

    task automatic double_flips();
        logic [DATA_W+PAR_W-1:0] v;
        int i;
        int j;
        for (int k = 0; k < 16; k++) begin
            i = rand_below(DATA_W + PAR_W);
            j = (i + 1 + rand_below(DATA_W + PAR_W - 1)) % (DATA_W + PAR_W);
            v = '0;
            v[i] = 1'b1;
            v[j] = 1'b1;
            issue_cmd(OP_WRITE, mem_addr_t'(k), rand_data(), '0);
            issue_cmd(OP_FLIP, mem_addr_t'(k), v[DATA_W-1:0], v[DATA_W+PAR_W-1:DATA_W]);
            issue_cmd(OP_READ, mem_addr_t'(k), '0, '0);
        end
        issue_cmd(OP_CLR_CNT, '0, '0, '0);
        wait_responses();
        check_count("sbit_cnt", '0, sbit_cnt);
        check_count("dbit_cnt", '0, dbit_cnt);
    endtask

    task automatic bad_commands();
        issue_cmd(3'd6, 5'd0, rand_data(), '1);
        issue_cmd(3'd7, 5'd3, rand_data(), '1);
        for (int a = MEM_DEPTH; a < 32; a++) begin
            issue_cmd(OP_WRITE, mem_addr_t'(a), rand_data(), '0);
            issue_cmd(OP_READ, mem_addr_t'(a), '0, '0);
            issue_cmd(OP_FLIP, mem_addr_t'(a), '1, '1);
        end
        // nop and counter clear ignore the address.
        issue_cmd(OP_NOP, 5'd31, '0, '0);
        issue_cmd(OP_CLR_CNT, 5'd30, '0, '0);
        for (int a = 0; a < MEM_DEPTH; a++) issue_cmd(OP_READ_RAW, mem_addr_t'(a), '0, '0);
        wait_responses();
    endtask

    // a read right behind its write must see the new word.
    task automatic streaming();
        mem_addr_t a;
        for (int k = 0; k < 12; k++) begin
            a = mem_addr_t'(rand_below(MEM_DEPTH));
            issue_cmd(OP_WRITE, a, rand_data(), '0);
            issue_cmd(OP_READ, a, '0, '0);
            issue_cmd(OP_READ_RAW, a, '0, '0);
        end
        wait_responses();
    endtask

    initial begin
        seed = 32'h6e15b628;
        errors = 0;
        checked = 0;
        sh_sc = '0;
        sh_dc = '0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = '0;
        cmd_addr = '0;
        cmd_data = '0;
        cmd_pflip = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_count("sbit_cnt", '0, sbit_cnt);
        check_count("dbit_cnt", '0, dbit_cnt);
        clean_write_read();
        single_data_flips();
        parity_flips();
        double_flips();
        bad_commands();
        streaming();
        $display("responses checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
source/ecc_pkg.sv
source/mem_cmd_pkg.sv
source/ecc_cmd_if.sv
source/ecc_word_if.sv
source/ecc_secded_28.sv
source/cmd_decode.sv
source/mem_execute.sv
source/result_check.sv
source/ecc_mem_top.sv
dv/ecc_mem_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module ecc_mem_tb -o ecc_mem_sim
./obj_dir/ecc_mem_sim > sim.log
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
